// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the control transfer instructions.
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // Full length view. Immediate bits are scattered over these fields.
    typedef struct packed {
        logic [6:0] imm_hi;   // Bits 31:25.
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvi_fields_t;

    // Compressed view, only the low halfword is meaningful.
    typedef struct packed {
        logic [15:0] unused;
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  rs1_rd;
        logic [4:0]  rs2;
        logic [1:0]  quadrant;
    } rvc_fields_t;

    typedef union packed {
        rvi_fields_t rvi;
        rvc_fields_t rvc;
    } inst_word_t;

endpackage

`default_nettype wire

// ==== verilog/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int CACHE_LINES = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         lookup,
    input  logic [fetch_pkg::XLEN-1:0]   lookup_addr,
    input  logic                         refill,
    input  logic [fetch_pkg::XLEN-1:0]   refill_addr,
    input  logic [fetch_pkg::XLEN-1:0]   refill_word,
    output logic                         hit,
    output fetch_pkg::inst_word_t        rd_word
);

    localparam int IDX_W = $clog2(CACHE_LINES);

    logic [CACHE_LINES-1:0]     valid;
    logic [fetch_pkg::XLEN-1:0] tag_mem  [CACHE_LINES];
    logic [fetch_pkg::XLEN-1:0] data_mem [CACHE_LINES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // Halfword index, bit 0 is always zero.
    assign rd_idx = lookup_addr[IDX_W:1];
    assign wr_idx = refill_addr[IDX_W:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (refill) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_mem[wr_idx]  <= refill_addr;
            data_mem[wr_idx] <= refill_word;
        end
    end

    // Result is held until the next lookup.
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (lookup) begin
            hit <= valid[rd_idx] && (tag_mem[rd_idx] == lookup_addr);
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            rd_word <= data_mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvi_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvi_predecode (
    input  fetch_pkg::inst_word_t       word,
    output logic [fetch_pkg::XLEN-1:0]  offset,
    output logic                        stop
);

    fetch_pkg::rvi_fields_t f;

    logic [fetch_pkg::XLEN-1:0] j_imm;
    logic [fetch_pkg::XLEN-1:0] b_imm;

    assign f = word.rvi;

    // imm[20|10:1|11|19:12] sits in bits 31:12.
    assign j_imm = {{(fetch_pkg::XLEN - 20){f.imm_hi[6]}},
                    f.rs1, f.funct3,
                    f.rs2[0],
                    f.imm_hi[5:0],
                    f.rs2[4:1],
                    1'b0};

    // imm[12|10:5] in bits 31:25, imm[4:1|11] in bits 11:7.
    assign b_imm = {{(fetch_pkg::XLEN - 12){f.imm_hi[6]}},
                    f.rd[0],
                    f.imm_hi[5:0],
                    f.rd[4:1],
                    1'b0};

    always_comb begin
        offset = {{(fetch_pkg::XLEN - 3){1'b0}}, 3'd4};
        stop   = 1'b0;
        case (f.opcode)
            fetch_pkg::OP_JAL: begin
                offset = j_imm;
            end
            fetch_pkg::OP_BRANCH: begin
                offset = b_imm;   // Static taken.
            end
            fetch_pkg::OP_JALR: begin
                stop = 1'b1;      // Target unknown until the backend resolves it.
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rvc_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvc_predecode (
    input  fetch_pkg::inst_word_t       word,
    output logic [fetch_pkg::XLEN-1:0]  offset,
    output logic                        stop
);

    localparam logic [1:0] Q1 = 2'b01;
    localparam logic [1:0] Q2 = 2'b10;

    localparam logic [2:0] F3_JAL  = 3'b001;
    localparam logic [2:0] F3_J    = 3'b101;
    localparam logic [2:0] F3_BEQZ = 3'b110;
    localparam logic [2:0] F3_BNEZ = 3'b111;
    localparam logic [2:0] F3_JR   = 3'b100;

    fetch_pkg::rvc_fields_t f;

    logic [fetch_pkg::XLEN-1:0] cj_imm;
    logic [fetch_pkg::XLEN-1:0] cb_imm;

    assign f = word.rvc;

    // Bits 12:2 carry offset[11|4|9:8|10|6|7|3:1|5].
    assign cj_imm = {{(fetch_pkg::XLEN - 11){f.b12}},
                     f.rs1_rd[1],
                     f.rs1_rd[3:2],
                     f.rs2[4],
                     f.rs1_rd[0],
                     f.rs2[0],
                     f.rs1_rd[4],
                     f.rs2[3:1],
                     1'b0};

    // offset[8|4:3] in bits 12:10, offset[7:6|2:1|5] in bits 6:2.
    assign cb_imm = {{(fetch_pkg::XLEN - 8){f.b12}},
                     f.rs2[4:3],
                     f.rs2[0],
                     f.rs1_rd[4:3],
                     f.rs2[2:1],
                     1'b0};

    always_comb begin
        offset = {{(fetch_pkg::XLEN - 2){1'b0}}, 2'd2};
        stop   = 1'b0;
        if (f.quadrant == Q1) begin
            case (f.funct3)
                F3_JAL, F3_J: begin
                    offset = cj_imm;
                end
                F3_BEQZ, F3_BNEZ: begin
                    offset = cb_imm;
                end
                default: begin
                end
            endcase
        end else if (f.quadrant == Q2 && f.funct3 == F3_JR && f.rs2 == 5'd0) begin
            stop = 1'b1;  // C.JR and C.JALR.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/next_pc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  logic [fetch_pkg::XLEN-1:0]  pc,
    input  fetch_pkg::inst_word_t       word,
    input  logic [fetch_pkg::XLEN-1:0]  rvi_offset,
    input  logic                        rvi_stop,
    input  logic [fetch_pkg::XLEN-1:0]  rvc_offset,
    input  logic                        rvc_stop,
    output logic [fetch_pkg::XLEN-1:0]  pred_pc,
    output logic                        stop,
    output logic                        compressed
);

    logic [fetch_pkg::XLEN-1:0] offset;

    // Low bits 11 mark a full length instruction.
    assign compressed = (word.rvi.opcode[1:0] != 2'b11);

    assign offset  = compressed ? rvc_offset : rvi_offset;
    assign stop    = compressed ? rvc_stop : rvi_stop;
    assign pred_pc = pc + offset;

endmodule

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                         CREDITS  = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         mem_req,
    output logic [fetch_pkg::XLEN-1:0]   mem_addr,
    input  logic                         mem_valid,
    input  logic [fetch_pkg::XLEN-1:0]   mem_data,
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]   redirect_pc,
    input  logic                         credit_return,
    output logic                         lookup,
    output logic [fetch_pkg::XLEN-1:0]   lookup_addr,
    output logic                         refill,
    output logic [fetch_pkg::XLEN-1:0]   refill_addr,
    output logic [fetch_pkg::XLEN-1:0]   refill_word,
    input  logic                         hit,
    input  fetch_pkg::inst_word_t        rd_word,
    input  logic [fetch_pkg::XLEN-1:0]   pred_pc,
    input  logic                         stop,
    input  logic                         compressed,
    output logic                         inst_valid,
    output logic [fetch_pkg::XLEN-1:0]   inst_word,
    output logic [fetch_pkg::XLEN-1:0]   inst_pc,
    output logic [fetch_pkg::XLEN-1:0]   inst_pred_pc,
    output logic                         inst_compressed
);

    localparam int CW = $clog2(CREDITS + 1);

    localparam logic [1:0] S_LOOKUP = 2'd0;
    localparam logic [1:0] S_CHECK  = 2'd1;
    localparam logic [1:0] S_WAIT   = 2'd2;
    localparam logic [1:0] S_STOP   = 2'd3;

    logic [1:0]                 state;
    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] miss_addr;
    logic [CW-1:0]              credits;
    logic                       stale;    // Reply still due for a dropped miss.
    logic                       issue;
    logic                       miss;

    assign issue = (state == S_CHECK) && hit && (credits != '0) && !redirect_valid;
    assign miss  = (state == S_CHECK) && !hit && !redirect_valid;

    assign lookup      = (state == S_LOOKUP);
    assign lookup_addr = pc;

    // A new request waits until any stale reply has come back.
    assign mem_req     = miss && !stale;
    assign mem_addr    = pc;
    assign refill      = mem_valid;
    assign refill_addr = miss_addr;
    assign refill_word = mem_data;

    assign inst_valid      = issue;
    assign inst_word       = rd_word;
    assign inst_pc         = pc;
    assign inst_pred_pc    = pred_pc;
    assign inst_compressed = compressed;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_LOOKUP;
            pc    <= RESET_PC;
        end else if (redirect_valid) begin
            state <= S_LOOKUP;
            pc    <= redirect_pc;
        end else begin
            case (state)
                S_LOOKUP: begin
                    state <= S_CHECK;
                end
                S_CHECK: begin
                    if (issue) begin
                        if (stop) begin
                            state <= S_STOP;
                        end else begin
                            state <= S_LOOKUP;
                            pc    <= pred_pc;
                        end
                    end else if (miss) begin
                        state <= stale ? S_LOOKUP : S_WAIT;  // Retry while blocked.
                    end
                end
                S_WAIT: begin
                    if (mem_valid) begin
                        state <= S_LOOKUP;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stale <= 1'b0;
        end else if (mem_valid) begin
            stale <= 1'b0;
        end else if (redirect_valid && state == S_WAIT) begin
            stale <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req) begin
            miss_addr <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(CREDITS);
        end else if (issue && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!issue && credit_return && credits != CW'(CREDITS)) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0,
    parameter int                         CREDITS     = 4,
    parameter int                         CACHE_LINES = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         mem_req,
    output logic [fetch_pkg::XLEN-1:0]   mem_addr,
    input  logic                         mem_valid,
    input  logic [fetch_pkg::XLEN-1:0]   mem_data,
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]   redirect_pc,
    input  logic                         credit_return,
    output logic                         inst_valid,
    output logic [fetch_pkg::XLEN-1:0]   inst_word,
    output logic [fetch_pkg::XLEN-1:0]   inst_pc,
    output logic [fetch_pkg::XLEN-1:0]   inst_pred_pc,
    output logic                         inst_compressed
);

    logic                       lookup;
    logic [fetch_pkg::XLEN-1:0] lookup_addr;
    logic                       refill;
    logic [fetch_pkg::XLEN-1:0] refill_addr;
    logic [fetch_pkg::XLEN-1:0] refill_word;
    logic                       hit;
    fetch_pkg::inst_word_t      rd_word;

    logic [fetch_pkg::XLEN-1:0] rvi_offset;
    logic                       rvi_stop;
    logic [fetch_pkg::XLEN-1:0] rvc_offset;
    logic                       rvc_stop;
    logic [fetch_pkg::XLEN-1:0] pred_pc;
    logic                       stop;
    logic                       compressed;

    fetch_ctrl #(
        .RESET_PC (RESET_PC),
        .CREDITS  (CREDITS)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_valid       (mem_valid),
        .mem_data        (mem_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .credit_return   (credit_return),
        .lookup          (lookup),
        .lookup_addr     (lookup_addr),
        .refill          (refill),
        .refill_addr     (refill_addr),
        .refill_word     (refill_word),
        .hit             (hit),
        .rd_word         (rd_word),
        .pred_pc         (pred_pc),
        .stop            (stop),
        .compressed      (compressed),
        .inst_valid      (inst_valid),
        .inst_word       (inst_word),
        .inst_pc         (inst_pc),
        .inst_pred_pc    (inst_pred_pc),
        .inst_compressed (inst_compressed)
    );

    icache #(
        .CACHE_LINES (CACHE_LINES)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .lookup_addr (lookup_addr),
        .refill      (refill),
        .refill_addr (refill_addr),
        .refill_word (refill_word),
        .hit         (hit),
        .rd_word     (rd_word)
    );

    // Both decodes run on every word.
    rvi_predecode u_rvi (
        .word   (rd_word),
        .offset (rvi_offset),
        .stop   (rvi_stop)
    );

    rvc_predecode u_rvc (
        .word   (rd_word),
        .offset (rvc_offset),
        .stop   (rvc_stop)
    );

    next_pc_select u_sel (
        .pc         (inst_pc),   // Current fetch PC.
        .word       (rd_word),
        .rvi_offset (rvi_offset),
        .rvi_stop   (rvi_stop),
        .rvc_offset (rvc_offset),
        .rvc_stop   (rvc_stop),
        .pred_pc    (pred_pc),
        .stop       (stop),
        .compressed (compressed)
    );

endmodule

`default_nettype wire

// ==== testbench/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

    localparam int CREDITS     = 4;
    localparam int TESTS       = 6;
    localparam int CYCLE_LIMIT = TESTS * 400;
    localparam int HWORDS      = 512;   // 1 KiB of program space.

    logic        clk;
    logic        rst;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [31:0] mem_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        credit_return;
    logic        inst_valid;
    logic [31:0] inst_word;
    logic [31:0] inst_pc;
    logic [31:0] inst_pred_pc;
    logic        inst_compressed;

    logic [15:0] prog [HWORDS];
    integer      seed;
    int          fails;
    int          pass_cnt;
    int          fail_cnt;
    int          test_fails;
    int          cycles;
    int          in_flight;
    int          loop_count;
    int          mem_cnt;
    logic        mem_busy;
    logic [31:0] pend_addr;
    logic [31:0] expect_pc;
    logic        halted;
    logic        withhold;
    logic        no_miss;

    fetch_unit #(
        .RESET_PC    (32'h0),
        .CREDITS     (CREDITS),
        .CACHE_LINES (32)
    ) dut0 (
        .clk             (clk),
        .rst             (rst),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_valid       (mem_valid),
        .mem_data        (mem_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .credit_return   (credit_return),
        .inst_valid      (inst_valid),
        .inst_word       (inst_word),
        .inst_pc         (inst_pc),
        .inst_pred_pc    (inst_pred_pc),
        .inst_compressed (inst_compressed)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        int idx;
        idx = (addr >> 1) % HWORDS;
        return {prog[(idx + 1) % HWORDS], prog[idx]};
    endfunction

    // Next PC under static prediction, decoded straight from the encodings.
    function automatic logic [31:0] ref_pred(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] off;
        off = (w[1:0] == 2'b11) ? 32'd4 : 32'd2;
        if (w[1:0] == 2'b11) begin
            if (w[6:0] == 7'h6f)
                off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            else if (w[6:0] == 7'h63)
                off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[1:0] == 2'b01) begin
            if (w[15:13] == 3'b001 || w[15:13] == 3'b101)
                off = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
            else if (w[15:13] == 3'b110 || w[15:13] == 3'b111)
                off = {{24{w[12]}}, w[6:5], w[2], w[11:10], w[4:3], 1'b0};
        end
        return pc + off;
    endfunction

    function automatic logic ref_stop(input logic [31:0] w);
        if (w[1:0] == 2'b11)
            return w[6:0] == 7'h67;
        return w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[6:2] == 5'd0;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'h6f};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [31:0] o);
        return {o[12], o[10:5], 10'd0, 3'b000, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [15:0] enc_cj(input logic [31:0] o);
        return {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction

    function automatic logic [15:0] enc_cbeqz(input logic [31:0] o);
        return {3'b110, o[8], o[4:3], 3'b000, o[7:6], o[2:1], o[5], 2'b01};
    endfunction

    task automatic put32(input logic [31:0] a, input logic [31:0] w);
        prog[a >> 1]       = w[15:0];
        prog[(a >> 1) + 1] = w[31:16];
    endtask

    task automatic put16(input logic [31:0] a, input logic [15:0] h);
        prog[a >> 1] = h;
    endtask

    task automatic load_program();
        for (int i = 0; i < HWORDS; i++)
            prog[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
        for (int i = 0; i < 8; i++)
            put32(32'h000 + 4 * i, 32'h00100093 + (i << 20));   // addi with varied imm.
        put32(32'h020, 32'h00008067);                          // jalr
        put16(32'h080, 16'h0505);
        put32(32'h082, 32'h00108093);
        put16(32'h086, 16'h0001);
        put16(32'h088, 16'h4505);
        put32(32'h08a, 32'h00210113);
        put16(32'h08e, 16'h852a);   // c.mv, quadrant 2 but not a jump.
        put16(32'h090, 16'h8082);
        put32(32'h100, enc_jal(32'h20));
        put32(32'h120, enc_beq(-32'sd16));
        put16(32'h110, enc_cj(32'h40));
        put16(32'h150, enc_cbeqz(-32'sd32));
        put16(32'h130, 16'h0001);
        put32(32'h132, 32'h00008067);
        put32(32'h180, 32'h00308093);
        put32(32'h184, 32'h00008067);
        put16(32'h1a0, 16'h0001);
        put16(32'h1a2, 16'h8082);
        put32(32'h1c0, 32'h00408093);
        put32(32'h1e0, 32'h00508093);
        put32(32'h1e4, 32'h00008067);
        for (int i = 0; i < 10; i++)
            put32(32'h200 + 4 * i, 32'h00600093 + (i << 20));
        put16(32'h228, 16'h8082);
        put16(32'h300, 16'h0001);
        put32(32'h302, 32'h00708093);
        put16(32'h306, enc_cbeqz(-32'sd6));
        put32(32'h320, 32'h00008067);
    endtask

    // Memory model with a random reply delay of 1 to 8 cycles, and the queue model.
    always @(posedge clk) begin
        if (rst) begin
            mem_valid     <= 1'b0;
            mem_busy      <= 1'b0;
            credit_return <= 1'b0;
            in_flight     <= 0;
        end else begin
            mem_valid <= 1'b0;
            if (mem_req) begin
                pend_addr <= mem_addr;
                mem_cnt   <= 1 + ($unsigned($random(seed)) % 8);
                mem_busy  <= 1'b1;
            end else if (mem_busy) begin
                if (mem_cnt == 1) begin
                    mem_valid <= 1'b1;
                    mem_data  <= prog_word(pend_addr);
                    mem_busy  <= 1'b0;
                end
                mem_cnt <= mem_cnt - 1;
            end
            // Credits come back after random delays.
            in_flight     <= in_flight + int'(inst_valid) - int'(credit_return);
            credit_return <= !withhold && (in_flight > int'(credit_return))
                             && ($unsigned($random(seed)) % 3 == 0);
        end
    end

    // Reference PC tracking.
    always @(posedge clk) begin
        if (rst) begin
            expect_pc  <= 32'h0;
            halted     <= 1'b0;
            loop_count <= 0;
        end else if (redirect_valid) begin
            expect_pc <= redirect_pc;
            halted    <= 1'b0;
        end else if (inst_valid) begin
            expect_pc <= inst_pred_pc;
            if (ref_stop(inst_word))
                halted <= 1'b1;
            if (inst_pc == 32'h306)
                loop_count <= loop_count + 1;
        end
    end

    a_word: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_word == prog_word(inst_pc))
        else begin
            fails++;
            $display("FAILED inst_word expected %h actual %h",
                     prog_word($sampled(inst_pc)), $sampled(inst_word));
        end

    a_len: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_compressed == (inst_word[1:0] != 2'b11))
        else begin
            fails++;
            $display("FAILED inst_compressed expected %h actual %h",
                     $sampled(inst_word[1:0]) != 2'b11, $sampled(inst_compressed));
        end

    a_pred: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_pred_pc == ref_pred(inst_pc, inst_word))
        else begin
            fails++;
            $display("FAILED inst_pred_pc expected %h actual %h",
                     ref_pred($sampled(inst_pc), $sampled(inst_word)), $sampled(inst_pred_pc));
        end

    a_pc: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_pc == expect_pc)
        else begin
            fails++;
            $display("FAILED inst_pc expected %h actual %h",
                     $sampled(expect_pc), $sampled(inst_pc));
        end

    a_addr: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr == expect_pc)
        else begin
            fails++;
            $display("FAILED mem_addr expected %h actual %h",
                     $sampled(expect_pc), $sampled(mem_addr));
        end

    a_halt: assert property (@(posedge clk) disable iff (rst) !(halted && inst_valid))
        else begin
            fails++;
            $display("Instruction issued while fetch should be stopped");
        end

    a_credit: assert property (@(posedge clk) disable iff (rst)
        in_flight <= CREDITS && !(in_flight == CREDITS && inst_valid))
        else begin
            fails++;
            $display("Issue without a free credit, %0d in flight", $sampled(in_flight));
        end

    a_hit: assert property (@(posedge clk) disable iff (rst) !(no_miss && mem_req))
        else begin
            fails++;
            $display("Memory request during the cached loop pass");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic send_redirect(input logic [31:0] pc);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic wait_halt();
        @(posedge clk);
        while (!halted)
            @(posedge clk);
    endtask

    task automatic end_test(input int num, input string name);
        if (fails == test_fails) begin
            pass_cnt++;
            $display("test %0d %s: pass", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: fail", num, name);
        end
        test_fails = fails;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        seed           = 32'h27e5_8125;
        mem_valid      = 1'b0;
        mem_data       = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        credit_return  = 1'b0;
        withhold       = 1'b0;
        no_miss        = 1'b0;
        cycles         = 0;
        fails          = 0;
        test_fails     = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        load_program();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        wait_halt();   // Fetch starts at the reset PC by itself.
        end_test(1, "straight_32bit");

        send_redirect(32'h080);
        wait_halt();
        end_test(2, "mixed_compressed");

        send_redirect(32'h100);
        wait_halt();
        end_test(3, "direct_jumps");

        send_redirect(32'h180);
        wait_halt();
        repeat (10) @(posedge clk);
        send_redirect(32'h1a0);
        wait_halt();
        send_redirect(32'h1c0);
        @(posedge clk);
        while (!mem_req)
            @(posedge clk);
        send_redirect(32'h1e0);   // Lands while the miss is outstanding.
        wait_halt();
        end_test(4, "indirect_redirect");

        withhold <= 1'b1;
        send_redirect(32'h200);
        while (in_flight != CREDITS)
            @(posedge clk);
        repeat (30) @(posedge clk);
        withhold <= 1'b0;
        wait_halt();
        end_test(5, "credits");

        send_redirect(32'h300);
        while (loop_count < 1)
            @(posedge clk);
        no_miss <= 1'b1;
        while (loop_count < 2)
            @(posedge clk);
        no_miss <= 1'b0;
        send_redirect(32'h320);
        wait_halt();
        end_test(6, "cache_hits");

        $display("Tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, fails);
        if (fail_cnt == 0 && fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
verilog/fetch_pkg.sv
verilog/icache.sv
verilog/rvi_predecode.sv
verilog/rvc_predecode.sv
verilog/next_pc_select.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
testbench/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= fetch_unit_tb
RTL_TOP   ?= fetch_unit
FLIST     ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TB_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
